//--- bench/tb_vga_pattern.sv
module tb_vga_pattern;

    import vga_pkg::*;

    // tiny screen of 24 x 20 clocks per frame
    localparam int H_ACTIVE     = 16;
    localparam int H_FRONT      = 2;
    localparam int H_SYNC       = 3;
    localparam int H_BACK       = 3;
    localparam int V_ACTIVE     = 16;
    localparam int V_FRONT      = 1;
    localparam int V_SYNC       = 2;
    localparam int V_BACK       = 1;
    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int CLK_PERIOD   = 8;
    localparam int DRIVE_DELAY  = 1;   // after the rising edge
    localparam int SAMPLE_DELAY = 3;   // outputs settled and next edge far off
    localparam int MAX_CMDS     = 128;

    logic              clk;
    logic              rst;
    logic [APB_AW-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_DW-1:0] pwdata;
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;
    logic              hsync;
    logic              vsync;
    color_t            red;
    color_t            green;
    color_t            blue;

    // whole trace kept in memory so the watchdog is sized before the run
    logic [7:0]        op  [0:MAX_CMDS-1];
    logic [APB_DW-1:0] arg [0:MAX_CMDS-1][0:4];
    int                n_cmds;
    int                n_frames;
    int                n_probes;
    int                budget_cycles;
    int                edge_cnt;   // edges since reset release = scan index

    vga_pattern_top #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK),
        .X_WIDTH  (5),        .Y_WIDTH (5)
    ) uut (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .hsync   (hsync),
        .vsync   (vsync),
        .red     (red),
        .green   (green),
        .blue    (blue)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk)
    begin
        if (rst)
            edge_cnt <= 0;
        else
            edge_cnt <= edge_cnt + 1;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp, input string where);
        stop_with_failure($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h at %s",
                                    name, got, exp, where));
    endtask

    // register map holds CTRL, SPEED and OFFSET only
    function automatic logic is_register(input logic [APB_AW-1:0] addr);
        case (addr)
            4'h0, 4'h4, 4'h8: return 1'b1;
            default:          return 1'b0;
        endcase
    endfunction

    // active low sync windows of the small screen
    function automatic logic hsync_expected(input int x);
        return !((x >= H_ACTIVE + H_FRONT) && (x < H_ACTIVE + H_FRONT + H_SYNC));
    endfunction

    function automatic logic vsync_expected(input int y);
        return !((y >= V_ACTIVE + V_FRONT) && (y < V_ACTIVE + V_FRONT + V_SYNC));
    endfunction

    task automatic load_trace();
        int                fd;
        int                code;
        int                ch;
        logic [7:0]        c;
        logic [APB_DW-1:0] a0;
        logic [APB_DW-1:0] a1;
        logic [APB_DW-1:0] a2;
        logic [APB_DW-1:0] a3;
        logic [APB_DW-1:0] a4;
        fd = $fopen("bench/vga_trace.txt", "r");
        if (fd == 0)
            stop_with_failure("could not open the trace file bench/vga_trace.txt");
        n_cmds   = 0;
        n_frames = 0;
        n_probes = 0;
        while (!$feof(fd))
        begin
            code = $fscanf(fd, " %c", c);   // command letter
            if (code != 1)
                break;
            if (c == "#")
            begin
                // skip the legend line
                do
                    ch = $fgetc(fd);
                while ((ch != 10) && (ch != -1));
                continue;
            end
            a0 = '0;
            a1 = '0;
            a2 = '0;
            a3 = '0;
            a4 = '0;
            case (c)
                "W":     code = $fscanf(fd, "%h %h", a0, a1) - 2;
                "R":     code = $fscanf(fd, "%h %h %h", a0, a1, a2) - 3;
                "F":     code = $fscanf(fd, "%d", a0) - 1;
                "P":     code = $fscanf(fd, "%d %d %h %h %h", a0, a1, a2, a3, a4) - 5;
                default: code = -1;
            endcase
            if ((code != 0) || (n_cmds >= MAX_CMDS))
                stop_with_failure($sformatf("trace entry %0d is malformed", n_cmds));
            op[n_cmds]     = c;
            arg[n_cmds][0] = a0;
            arg[n_cmds][1] = a1;
            arg[n_cmds][2] = a2;
            arg[n_cmds][3] = a3;
            arg[n_cmds][4] = a4;
            if (c == "F")
                n_frames += int'(a0);
            if (c == "P")
                n_probes++;   // may wait up to a frame
            n_cmds++;
        end
        $fclose(fd);
    endtask

    // one setup and one access cycle then back to idle
    task automatic apb_transfer(input logic wr, input logic [APB_AW-1:0] addr,
                                input logic [APB_DW-1:0] wdata,
                                output logic [APB_DW-1:0] rdata, output logic err);
        @(posedge clk);
        #DRIVE_DELAY;
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        #(SAMPLE_DELAY - DRIVE_DELAY);
        assert (pready === 1'b0)
            else report_mismatch("pready", 32'(pready), 32'h0, "APB setup cycle");
        assert (pslverr === 1'b0)
            else report_mismatch("pslverr", 32'(pslverr), 32'h0, "APB setup cycle");
        @(posedge clk);
        #DRIVE_DELAY;
        penable = 1'b1;
        #(SAMPLE_DELAY - DRIVE_DELAY);
        assert (pready === 1'b1)
            else report_mismatch("pready", 32'(pready), 32'h1, "APB access cycle");
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);   // write lands here
        #DRIVE_DELAY;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // returns just after the edge that starts each new frame
    task automatic wait_frames(input int n);
        int seen;
        seen = 0;
        while (seen < n)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            if ((edge_cnt % FRAME_CYCLES) == 0)
                seen++;
        end
    endtask

    task automatic probe_pixel(input int px, input int py, input color_t exp_r,
                               input color_t exp_g, input color_t exp_b, input string where);
        int pos;
        int sx;
        int sy;
        sx = -1;
        sy = -1;
        while (!((sx == px) && (sy == py)))
        begin
            @(posedge clk);
            #SAMPLE_DELAY;
            pos = edge_cnt - 1;   // ports lag the scan by one cycle
            sx  = pos % H_TOTAL;
            sy  = (pos / H_TOTAL) % V_TOTAL;
        end
        assert (red === exp_r) else report_mismatch("red", 32'(red), 32'(exp_r), where);
        assert (green === exp_g) else report_mismatch("green", 32'(green), 32'(exp_g), where);
        assert (blue === exp_b) else report_mismatch("blue", 32'(blue), 32'(exp_b), where);
        assert (hsync === hsync_expected(px))
            else report_mismatch("hsync", 32'(hsync), 32'(hsync_expected(px)), where);
        assert (vsync === vsync_expected(py))
            else report_mismatch("vsync", 32'(vsync), 32'(vsync_expected(py)), where);
    endtask

    task automatic run_command(input int i);
        logic [APB_DW-1:0] rdata;
        logic              err;
        logic              exp_err;
        string             where;
        where = $sformatf("trace command %0d", i);
        case (op[i])
            "W":
            begin
                exp_err = !is_register(arg[i][0][APB_AW-1:0]);   // unmapped address
                apb_transfer(1'b1, arg[i][0][APB_AW-1:0], arg[i][1], rdata, err);
                assert (err === exp_err)
                    else report_mismatch("pslverr", 32'(err), 32'(exp_err), where);
            end
            "R":
            begin
                apb_transfer(1'b0, arg[i][0][APB_AW-1:0], '0, rdata, err);
                assert (rdata === arg[i][1])
                    else report_mismatch("prdata", rdata, arg[i][1], where);
                assert (err === arg[i][2][0])
                    else report_mismatch("pslverr", 32'(err), 32'(arg[i][2][0]), where);
            end
            "F":
                wait_frames(int'(arg[i][0]));
            "P":
                probe_pixel(int'(arg[i][0]), int'(arg[i][1]), arg[i][2][COLOR_W-1:0],
                            arg[i][3][COLOR_W-1:0], arg[i][4][COLOR_W-1:0], where);
            default:
                stop_with_failure($sformatf("unknown command in %s", where));
        endcase
    endtask

    // watchdog armed once the trace length is known
    initial
    begin
        wait (budget_cycles > 0);
        repeat (budget_cycles) @(posedge clk);
        stop_with_failure($sformatf("timeout, trace not done after %0d cycles", budget_cycles));
    end

    initial
    begin
        clk     = 1'b0;
        rst     = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        load_trace();
        budget_cycles = (n_frames + n_probes + 2) * FRAME_CYCLES + 8 * n_cmds + 64;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        for (int i = 0; i < n_cmds; i++)
            run_command(i);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- bench/vga_pattern_assert.sv
module vga_pattern_assert #(
    parameter int H_SYNC = 96
) (
    input logic clk,
    input logic rst,
    input logic frame_start,
    input logic hsync,
    input logic psel,
    input logic penable,
    input logic pready
);

    int low_cnt;   // cycles hsync has been low so far

    always @(posedge clk)
    begin
        if (rst || hsync)
            low_cnt <= 0;
        else
            low_cnt <= low_cnt + 1;
    end

    // frame pulse never two cycles in a row
    frame_single: assert property (@(posedge clk) disable iff (rst)
        frame_start |=> !frame_start)
        else $error("frame_start lasted more than one cycle");

    // ready only inside an access cycle
    ready_in_access: assert property (@(posedge clk) disable iff (rst)
        pready |-> (psel && penable))
        else $error("pready high outside an access cycle");

    hsync_width: assert property (@(posedge clk) disable iff (rst)
        $rose(hsync) |-> (low_cnt == H_SYNC))
        else $error("hsync pulse was %0d cycles, expected %0d", low_cnt, H_SYNC);

endmodule

// the timing copy checks sync width and the apb copy checks frame pulse and ready
bind vga_timing vga_pattern_assert #(.H_SYNC(H_SYNC)) u_sync_chk (
    .clk         (clk),
    .rst         (rst),
    .frame_start (1'b0),
    .hsync       (hsync_q),
    .psel        (1'b0),
    .penable     (1'b0),
    .pready      (1'b0)
);

bind scroll_ctrl vga_pattern_assert u_apb_chk (
    .clk         (clk),
    .rst         (rst),
    .frame_start (frame_start),
    .hsync       (1'b1),     // no sync here
    .psel        (psel),
    .penable     (penable),
    .pready      (pready)
);

//--- bench/vga_trace.txt
# W addr data | R addr data err | F frames | P x y red green blue
# addr, data and colors in hex; x, y, frames and err in decimal
R 0 00000000 0
R 4 00000000 0
R 8 00000000 0
P 0 0 0 0 0
P 3 2 8 1 0
P 10 5 9 5 0
P 1 12 e 5 0
P 15 15 d 0 0
P 19 4 0 0 0
P 5 17 0 0 0
P 16 16 0 0 0
W c 000000ff
R c 00000000 1
R 0 00000000 0
W 0 00000008
R 0 00000008 0
P 3 2 8 1 f
P 20 3 0 0 0
P 4 18 0 0 0
W 0 00000000
W 8 00000305
R 8 00000305 0
P 3 2 d e 0
P 10 5 e 2 0
P 15 15 2 d 0
W 8 00001c1a
R 8 00001c1a 0
P 3 2 2 5 0
W 8 00000000
W 4 00000001
R 4 00000001 0
F 1
W 0 00000007
R 0 00000007 0
F 1
R 8 00000000 0
P 3 2 8 1 0
F 1
R 8 00000101 0
P 3 2 9 0 0
F 2
R 8 00000202 0
P 10 5 b 3 0
W 0 00000003
F 2
R 8 00000203 0
P 0 1 4 d 0
F 2
R 8 00000204 0
W 0 00000000
F 2
R 8 00000204 0
P 15 15 1 e 0

//--- run.sh
#!/bin/sh
# build and run the trace testbench with verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_vga_pattern -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vtb_vga_pattern
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation ended with status $status"
    exit "$status"
fi

exit 0

//--- sources.f
src/vga_pkg.sv
src/scan_if.sv
src/vga_timing.sv
src/scroll_ctrl.sv
src/pattern_gen.sv
src/vga_pattern_top.sv
bench/vga_pattern_assert.sv
bench/tb_vga_pattern.sv

//--- src/pattern_gen.sv
module pattern_gen #(
    parameter int X_WIDTH = 10,
    parameter int Y_WIDTH = 10
) (
    input  logic             clk,
    input  logic             rst,
    scan_if.sink             scan,
    input  vga_pkg::offset_t dx,
    input  vga_pkg::offset_t dy,
    input  logic             blue_on,
    output vga_pkg::color_t  red,
    output vga_pkg::color_t  green,
    output vga_pkg::color_t  blue,
    output logic             hsync_out,
    output logic             vsync_out
);

    import vga_pkg::*;

    color_t xc;        // coarse column, 16 bands across
    color_t yc;        // coarse row
    color_t red_d;
    color_t green_d;
    color_t blue_d;

    // top bit dropped, next four taken
    assign xc = scan.x[X_WIDTH-2 -: COLOR_W];
    assign yc = scan.y[Y_WIDTH-2 -: COLOR_W];

    // colors wrap mod 16 through the 4 bit targets
    always_comb
    begin
        red_d   = '0;
        green_d = '0;
        blue_d  = '0;
        if (scan.display_on)
        begin
            red_d   = xc + xc + yc + dx[COLOR_W-1:0];   // diagonal bands, scroll right
            green_d = xc - yc - dy[COLOR_W-1:0];        // opposite diagonal
            blue_d  = {COLOR_W{blue_on}};
        end
    end

    // one cycle latency, syncs ride along with the color
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            red       <= '0;
            green     <= '0;
            blue      <= '0;
            hsync_out <= 1'b1;
            vsync_out <= 1'b1;
        end
        else
        begin
            red       <= red_d;
            green     <= green_d;
            blue      <= blue_d;
            hsync_out <= scan.hsync;
            vsync_out <= scan.vsync;
        end
    end

endmodule

//--- src/scan_if.sv
interface scan_if #(
    parameter int X_WIDTH = 10,
    parameter int Y_WIDTH = 10
);

    logic [X_WIDTH-1:0] x;            // current column
    logic [Y_WIDTH-1:0] y;            // current row
    logic               display_on;   // inside the visible area
    logic               hsync;        // active low
    logic               vsync;        // active low
    logic               frame_start;  // last pixel of the frame

    // timing generator side
    modport source (output x, y, display_on, hsync, vsync, frame_start);

    // pattern side, frame_start is taken off the instance at the top
    modport sink (input x, y, display_on, hsync, vsync);

endinterface

//--- src/scroll_ctrl.sv
module scroll_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [vga_pkg::APB_AW-1:0] paddr,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [vga_pkg::APB_DW-1:0] pwdata,
    output logic [vga_pkg::APB_DW-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr,
    input  logic                       frame_start,
    output vga_pkg::offset_t           dx,
    output vga_pkg::offset_t           dy,
    output logic                       blue_on
);

    import vga_pkg::*;

    ctrl_state_t        state;      // phase of the previous cycle
    logic               access;     // psel and penable
    logic               addr_ok;
    logic               acc_ok;     // well ordered access to a real register
    logic               wr_en;
    logic               step;       // offset update this cycle
    logic [CTRL_W-1:0]  ctrl_q;
    logic [SPEED_W-1:0] speed_q;
    logic [SPEED_W-1:0] div_q;      // frames since last step
    offset_t            dx_q;
    offset_t            dy_q;

    always_comb
    begin
        access  = psel && penable;
        addr_ok = (paddr == ADDR_CTRL) || (paddr == ADDR_SPEED) || (paddr == ADDR_OFFSET);
        acc_ok  = access && (state == SETUP) && addr_ok;   // access must follow setup
        wr_en   = acc_ok && pwrite;
        step    = frame_start && ctrl_q[CTRL_EN] && (div_q == speed_q);
    end

    // track bus phases
    always_ff @(posedge clk)
    begin
        if (rst)
            state <= IDLE;
        else if (!psel)
            state <= IDLE;
        else if (!penable)
            state <= SETUP;
        else
            state <= ACCESS;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ctrl_q  <= '0;
            speed_q <= '0;
            div_q   <= '0;
            dx_q    <= '0;
            dy_q    <= '0;
        end
        else
        begin
            if (wr_en && (paddr == ADDR_CTRL))
                ctrl_q <= pwdata[CTRL_W-1:0];
            if (wr_en && (paddr == ADDR_SPEED))
                speed_q <= pwdata[SPEED_W-1:0];

            // frame divider, restarts whenever animation is off
            if (!ctrl_q[CTRL_EN])
                div_q <= '0;
            else if (frame_start)
                div_q <= (div_q == speed_q) ? '0 : div_q + 1'b1;

            // bus write beats a same cycle step
            if (wr_en && (paddr == ADDR_OFFSET))
            begin
                dx_q <= pwdata[OFFSET_W-1:0];
                dy_q <= pwdata[2*OFFSET_W-1:OFFSET_W];
            end
            else if (step)
            begin
                dx_q <= dx_q + OFFSET_W'(ctrl_q[CTRL_STEP_X]);
                dy_q <= dy_q + OFFSET_W'(ctrl_q[CTRL_STEP_Y]);
            end
        end
    end

    // read mux, zero unless a good read access
    always_comb
    begin
        prdata = '0;
        if (acc_ok && !pwrite)
        begin
            case (paddr)
                ADDR_CTRL:   prdata = APB_DW'(ctrl_q);
                ADDR_SPEED:  prdata = APB_DW'(speed_q);
                ADDR_OFFSET: prdata = APB_DW'({dy_q, dx_q});
                default:     prdata = '0;
            endcase
        end
    end

    assign pready  = access;              // no wait states
    assign pslverr = access && !acc_ok;   // bad address or out of order
    assign dx      = dx_q;
    assign dy      = dy_q;
    assign blue_on = ctrl_q[CTRL_BLUE];

endmodule

//--- src/vga_pattern_top.sv
module vga_pattern_top #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33,
    parameter int X_WIDTH  = 10,
    parameter int Y_WIDTH  = 10
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [vga_pkg::APB_AW-1:0] paddr,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [vga_pkg::APB_DW-1:0] pwdata,
    output logic [vga_pkg::APB_DW-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr,
    output logic                       hsync,
    output logic                       vsync,
    output vga_pkg::color_t            red,
    output vga_pkg::color_t            green,
    output vga_pkg::color_t            blue
);

    import vga_pkg::*;

    offset_t dx;
    offset_t dy;
    logic    blue_on;

    scan_if #(.X_WIDTH(X_WIDTH), .Y_WIDTH(Y_WIDTH)) scan ();

    vga_timing #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK),
        .X_WIDTH  (X_WIDTH),  .Y_WIDTH (Y_WIDTH)
    ) u_timing (
        .clk  (clk),
        .rst  (rst),
        .scan (scan.source)
    );

    // frame_start taken straight off the interface instance
    scroll_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .frame_start (scan.frame_start),
        .dx          (dx),
        .dy          (dy),
        .blue_on     (blue_on)
    );

    pattern_gen #(.X_WIDTH(X_WIDTH), .Y_WIDTH(Y_WIDTH)) u_pattern (
        .clk       (clk),
        .rst       (rst),
        .scan      (scan.sink),
        .dx        (dx),
        .dy        (dy),
        .blue_on   (blue_on),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .hsync_out (hsync),
        .vsync_out (vsync)
    );

endmodule

//--- src/vga_pkg.sv
package vga_pkg;

    // apb bus geometry
    localparam int APB_AW = 4;
    localparam int APB_DW = 32;

    // field widths
    localparam int COLOR_W  = 4;   // one vga channel
    localparam int OFFSET_W = 8;   // scroll offset, low nibble reaches the color
    localparam int SPEED_W  = 8;   // frames per step, minus one
    localparam int CTRL_W   = 4;

    typedef logic [COLOR_W-1:0]  color_t;
    typedef logic [OFFSET_W-1:0] offset_t;

    // register map, word aligned
    localparam logic [APB_AW-1:0] ADDR_CTRL   = 4'h0;
    localparam logic [APB_AW-1:0] ADDR_SPEED  = 4'h4;
    localparam logic [APB_AW-1:0] ADDR_OFFSET = 4'h8;   // dy in 15..8, dx in 7..0

    // ctrl bit positions
    localparam int CTRL_EN     = 0;   // animation enable
    localparam int CTRL_STEP_X = 1;   // dx += 1 per step
    localparam int CTRL_STEP_Y = 2;   // dy += 1 per step
    localparam int CTRL_BLUE   = 3;   // blue channel on

    // last apb phase seen on the bus
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        SETUP  = 2'd1,
        ACCESS = 2'd2
    } ctrl_state_t;

endpackage

//--- src/vga_timing.sv
module vga_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33,
    parameter int X_WIDTH  = 10,
    parameter int Y_WIDTH  = 10
) (
    input  logic   clk,
    input  logic   rst,
    scan_if.source scan
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // counter limits and sync windows, sized to the coordinates
    localparam logic [X_WIDTH-1:0] X_LAST     = X_WIDTH'(H_TOTAL - 1);
    localparam logic [Y_WIDTH-1:0] Y_LAST     = Y_WIDTH'(V_TOTAL - 1);
    localparam logic [X_WIDTH-1:0] X_VIS      = X_WIDTH'(H_ACTIVE);
    localparam logic [Y_WIDTH-1:0] Y_VIS      = Y_WIDTH'(V_ACTIVE);
    localparam logic [X_WIDTH-1:0] HS_FIRST   = X_WIDTH'(H_ACTIVE + H_FRONT);
    localparam logic [X_WIDTH-1:0] HS_LAST    = X_WIDTH'(H_ACTIVE + H_FRONT + H_SYNC - 1);
    localparam logic [Y_WIDTH-1:0] VS_FIRST   = Y_WIDTH'(V_ACTIVE + V_FRONT);
    localparam logic [Y_WIDTH-1:0] VS_LAST    = Y_WIDTH'(V_ACTIVE + V_FRONT + V_SYNC - 1);

    logic [X_WIDTH-1:0] x_q;
    logic [X_WIDTH-1:0] x_nxt;
    logic [Y_WIDTH-1:0] y_q;
    logic [Y_WIDTH-1:0] y_nxt;
    logic               x_wrap;
    logic               y_wrap;
    logic               hsync_q;
    logic               vsync_q;
    logic               display_on_q;

    // next position, y moves only when x wraps
    always_comb
    begin
        x_wrap = (x_q == X_LAST);
        y_wrap = (y_q == Y_LAST);
        x_nxt  = x_wrap ? '0 : x_q + 1'b1;
        if (x_wrap)
            y_nxt = y_wrap ? '0 : y_q + 1'b1;
        else
            y_nxt = y_q;
    end

    // syncs and enable decoded from the next position so all flops agree
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            x_q          <= '0;
            y_q          <= '0;
            hsync_q      <= 1'b1;   // idle high
            vsync_q      <= 1'b1;
            display_on_q <= 1'b1;   // matches (0,0)
        end
        else
        begin
            x_q          <= x_nxt;
            y_q          <= y_nxt;
            hsync_q      <= !((x_nxt >= HS_FIRST) && (x_nxt <= HS_LAST));
            vsync_q      <= !((y_nxt >= VS_FIRST) && (y_nxt <= VS_LAST));
            display_on_q <= (x_nxt < X_VIS) && (y_nxt < Y_VIS);
        end
    end

    assign scan.x           = x_q;
    assign scan.y           = y_q;
    assign scan.hsync       = hsync_q;
    assign scan.vsync       = vsync_q;
    assign scan.display_on  = display_on_q;
    assign scan.frame_start = x_wrap && y_wrap;   // one cycle, last pixel

endmodule
